// File: verilog/soc_pkg.sv
//////////////////////////////////////////////////
// Bus request and response structs, SPI pin struct
// and the address map constants of the SoC
//////////////////////////////////////////////////

`default_nettype none

package soc_pkg;

    // Single-cycle request strobe from the bus master
    typedef struct packed {
        logic        sel;
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
        logic [3:0]  wmask;
    } bus_req_t;

    // Ack one cycle after the strobe, rdata valid with ack and zero otherwise
    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic sclk;
        logic csn;
        logic mosi;
    } spi_pins_t;

    // Regions from address bits 31 to 28
    localparam logic [3:0] REGION_RAM = 4'd1;
    localparam logic [3:0] REGION_DEV = 4'd2;

    // Device pages from address bits 15 to 12
    localparam logic [3:0] PAGE_SYS     = 4'd0;
    localparam logic [3:0] PAGE_DISPLAY = 4'd1;
    localparam logic [3:0] PAGE_UART    = 4'd2;
    localparam logic [3:0] PAGE_KBD     = 4'd5;
    localparam logic [3:0] PAGE_SD      = 4'd6;

    // Register offsets within a page
    localparam logic [11:0] OFS_DATA   = 12'd0;
    localparam logic [11:0] OFS_STATUS = 12'd4;

endpackage

`default_nettype wire

// File: verilog/byte_fifo.sv
//////////////////////////////////////////////////
// First-word-fall-through byte FIFO
//////////////////////////////////////////////////

`default_nettype none

module byte_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] wr_data_i,
    input  wire logic       wr_en_i,
    output      logic       full_o,
    output      logic [7:0] rd_data_o,
    input  wire logic       rd_en_i,
    output      logic       empty_o
);

    logic [7:0]          mem [2**DEPTH_LOG2];
    // Top bit is the wrap flag
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                     (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    // Head visible without a read
    assign rd_data_o = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en_i && !full_o)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en_i && !empty_o)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && !full_o)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data_i;
    end

endmodule

`default_nettype wire

// File: verilog/bus_ram.sv
//////////////////////////////////////////////////
// Single-port word RAM with byte write masks
//////////////////////////////////////////////////

`default_nettype none

module bus_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic              clk,
    input  wire soc_pkg::bus_req_t bus_req_i,
    output      soc_pkg::bus_rsp_t bus_rsp_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] word_idx;
    logic          ack_q;
    logic [31:0]   rdata_q;

    // Byte address to word index
    assign word_idx = bus_req_i.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (bus_req_i.sel && bus_req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_req_i.wmask[i])
                    mem[word_idx][8*i +: 8] <= bus_req_i.wdata[8*i +: 8];
            end
        end
    end

    // Zero when idle so the top level can OR the responses
    always_ff @(posedge clk) begin
        ack_q <= bus_req_i.sel;
        if (bus_req_i.sel && !bus_req_i.we)
            rdata_q <= mem[word_idx];
        else
            rdata_q <= '0;
    end

    assign bus_rsp_o.ack   = ack_q;
    assign bus_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: verilog/sys_timer.sv
//////////////////////////////////////////////////
// System timer with periodic interrupt, EOI
// handshake and lost-tick counter
//////////////////////////////////////////////////

`default_nettype none

module sys_timer #(
    parameter int CLK_HZ  = 12_000_000,
    parameter int TICK_HZ = 1000
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire soc_pkg::bus_req_t bus_req_i,
    input  wire logic              eoi_i,
    output      soc_pkg::bus_rsp_t bus_rsp_o,
    output      logic              irq_o
);
    import soc_pkg::*;

    localparam logic [31:0] RELOAD = 32'(CLK_HZ / TICK_HZ - 1);

    logic [31:0] count;
    logic        irq_ena;
    logic        wait_handling;
    logic [31:0] lost_cnt;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic        wr;
    logic        rd;
    logic [11:0] ofs;

    assign ofs = bus_req_i.addr[11:0];
    assign wr  = bus_req_i.sel && bus_req_i.we;
    assign rd  = bus_req_i.sel && !bus_req_i.we;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count         <= RELOAD;
            irq_ena       <= 1'b0;
            irq_o         <= 1'b0;
            wait_handling <= 1'b0;
            lost_cnt      <= '0;
            ack_q         <= 1'b0;
        end else begin
            ack_q <= bus_req_i.sel;
            if (wr && ofs == OFS_DATA)
                irq_ena <= bus_req_i.wdata[0];

            // Handler has started once eoi drops, irq releases when it returns high
            if (wait_handling) begin
                if (!eoi_i)
                    wait_handling <= 1'b0;
            end else if (irq_o && eoi_i) begin
                irq_o <= 1'b0;
            end

            count <= count - 1'b1;
            if (count == '0) begin
                count <= RELOAD;
                // Disabled ticks are not counted as lost
                if (irq_ena) begin
                    if (!wait_handling && eoi_i) begin
                        irq_o         <= 1'b1;
                        wait_handling <= 1'b1;
                    end else begin
                        lost_cnt <= lost_cnt + 1'b1;
                    end
                end
            end

            if (wr && ofs == OFS_STATUS)
                lost_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd && ofs == OFS_DATA)
            rdata_q <= {31'd0, irq_ena};
        else if (rd && ofs == OFS_STATUS)
            rdata_q <= lost_cnt;
        else
            rdata_q <= '0;
    end

    assign bus_rsp_o.ack   = ack_q;
    assign bus_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: verilog/io_regs.sv
//////////////////////////////////////////////////
// Display, UART, keyboard and SD-card registers
//////////////////////////////////////////////////

`default_nettype none

module io_regs #(
    parameter int UART_FIFO_LOG2 = 4,
    parameter int KBD_FIFO_LOG2  = 5
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire soc_pkg::bus_req_t  bus_req_i,
    input  wire logic [7:0]         uart_rx_byte_i,
    input  wire logic               uart_rx_valid_i,
    input  wire logic               uart_busy_i,
    input  wire logic [7:0]         kbd_code_i,
    input  wire logic               kbd_strobe_i,
    input  wire logic               sd_miso_i,
    output      soc_pkg::bus_rsp_t  bus_rsp_o,
    output      logic [7:0]         display_o,
    output      logic [7:0]         uart_tx_byte_o,
    output      logic               uart_tx_strobe_o,
    output      soc_pkg::spi_pins_t sd_o
);
    import soc_pkg::*;

    logic [3:0]  page;
    logic [11:0] ofs;
    logic        wr;
    logic        rd;
    logic        disp_wr;
    logic        tx_wr;
    logic        sd_wr;
    logic        uart_empty;
    logic        uart_full;
    logic        uart_deq;
    logic [7:0]  uart_head;
    logic [7:0]  uart_code;
    logic        kbd_empty;
    logic        kbd_full;
    logic        kbd_deq;
    logic [7:0]  kbd_head;
    logic [7:0]  kbd_code;
    logic        ack_q;
    logic [31:0] rd_data;
    logic [31:0] rdata_q;

    assign page = bus_req_i.addr[15:12];
    assign ofs  = bus_req_i.addr[11:0];
    assign wr   = bus_req_i.sel && bus_req_i.we;
    assign rd   = bus_req_i.sel && !bus_req_i.we;

    assign disp_wr  = wr && page == PAGE_DISPLAY;
    assign tx_wr    = wr && page == PAGE_UART && ofs == OFS_DATA;
    assign sd_wr    = wr && page == PAGE_SD && ofs == OFS_DATA;
    // Dequeue of an empty FIFO does nothing
    assign uart_deq = wr && page == PAGE_UART && ofs == OFS_STATUS && !uart_empty;
    assign kbd_deq  = wr && page == PAGE_KBD && ofs == OFS_DATA && !kbd_empty;

    byte_fifo #(.DEPTH_LOG2(UART_FIFO_LOG2)) uart_rx_fifo (
        .clk      (clk),
        .reset_i  (reset_i),
        .wr_data_i(uart_rx_byte_i),
        .wr_en_i  (uart_rx_valid_i && !uart_full),
        .full_o   (uart_full),
        .rd_data_o(uart_head),
        .rd_en_i  (uart_deq),
        .empty_o  (uart_empty)
    );

    byte_fifo #(.DEPTH_LOG2(KBD_FIFO_LOG2)) kbd_fifo (
        .clk      (clk),
        .reset_i  (reset_i),
        .wr_data_i(kbd_code_i),
        .wr_en_i  (kbd_strobe_i && !kbd_full),
        .full_o   (kbd_full),
        .rd_data_o(kbd_head),
        .rd_en_i  (kbd_deq),
        .empty_o  (kbd_empty)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o        <= 8'd0;
            uart_tx_strobe_o <= 1'b0;
            sd_o             <= '{sclk: 1'b0, csn: 1'b1, mosi: 1'b0};
            ack_q            <= 1'b0;
        end else begin
            ack_q            <= bus_req_i.sel;
            uart_tx_strobe_o <= tx_wr;
            if (disp_wr)
                display_o <= bus_req_i.wdata[7:0];
            // cs is active high on the bus, csn on the pin
            if (sd_wr)
                sd_o <= '{sclk: bus_req_i.wdata[2], csn: ~bus_req_i.wdata[1],
                          mosi: bus_req_i.wdata[0]};
        end
    end

    always_comb begin
        rd_data = '0;
        case (page)
            PAGE_DISPLAY: rd_data = {24'd0, display_o};
            PAGE_UART: begin
                if (ofs == OFS_DATA)
                    rd_data = {24'd0, uart_code};
                else if (ofs == OFS_STATUS)
                    rd_data = {30'd0, ~uart_empty, uart_busy_i};
            end
            PAGE_KBD: begin
                if (ofs == OFS_DATA)
                    rd_data = {31'd0, ~kbd_empty};
                else if (ofs == OFS_STATUS)
                    rd_data = {24'd0, kbd_code};
            end
            PAGE_SD: begin
                if (ofs == OFS_DATA)
                    rd_data = {31'd0, sd_miso_i};
            end
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (tx_wr)
            uart_tx_byte_o <= bus_req_i.wdata[7:0];
        if (uart_deq)
            uart_code <= uart_head;
        if (kbd_deq)
            kbd_code <= kbd_head;
        rdata_q <= rd ? rd_data : 32'd0;
    end

    assign bus_rsp_o.ack   = ack_q;
    assign bus_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: verilog/soc_bus.sv
//////////////////////////////////////////////////
// SoC fabric top level with region decode,
// response mux and unmapped-address responder
//////////////////////////////////////////////////

`default_nettype none

module soc_bus #(
    parameter int CLK_HZ         = 12_000_000,
    parameter int TICK_HZ        = 1000,
    parameter int RAM_WORDS      = 1024,
    parameter int UART_FIFO_LOG2 = 4,
    parameter int KBD_FIFO_LOG2  = 5
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire soc_pkg::bus_req_t  bus_req_i,
    input  wire logic               timer_eoi_i,
    input  wire logic [7:0]         uart_rx_byte_i,
    input  wire logic               uart_rx_valid_i,
    input  wire logic               uart_busy_i,
    input  wire logic [7:0]         kbd_code_i,
    input  wire logic               kbd_strobe_i,
    input  wire logic               sd_miso_i,
    output      soc_pkg::bus_rsp_t  bus_rsp_o,
    output      logic               timer_irq_o,
    output      logic [7:0]         display_o,
    output      logic [7:0]         uart_tx_byte_o,
    output      logic               uart_tx_strobe_o,
    output      soc_pkg::spi_pins_t sd_o
);
    import soc_pkg::*;

    logic     is_ram;
    logic     is_dev;
    logic     is_sys;
    bus_req_t ram_req;
    bus_req_t sys_req;
    bus_req_t io_req;
    bus_rsp_t ram_rsp;
    bus_rsp_t sys_rsp;
    bus_rsp_t io_rsp;
    logic     unmapped_ack;

    assign is_ram = bus_req_i.addr[31:28] == REGION_RAM;
    assign is_dev = bus_req_i.addr[31:28] == REGION_DEV;
    assign is_sys = is_dev && bus_req_i.addr[15:12] == PAGE_SYS;

    // Same request to every slave, sel only where it decodes
    always_comb begin
        ram_req     = bus_req_i;
        sys_req     = bus_req_i;
        io_req      = bus_req_i;
        ram_req.sel = bus_req_i.sel && is_ram;
        sys_req.sel = bus_req_i.sel && is_sys;
        io_req.sel  = bus_req_i.sel && is_dev && !is_sys;
    end

    bus_ram #(.RAM_WORDS(RAM_WORDS)) ram (
        .clk      (clk),
        .bus_req_i(ram_req),
        .bus_rsp_o(ram_rsp)
    );

    sys_timer #(.CLK_HZ(CLK_HZ), .TICK_HZ(TICK_HZ)) timer (
        .clk      (clk),
        .reset_i  (reset_i),
        .bus_req_i(sys_req),
        .eoi_i    (timer_eoi_i),
        .bus_rsp_o(sys_rsp),
        .irq_o    (timer_irq_o)
    );

    io_regs #(.UART_FIFO_LOG2(UART_FIFO_LOG2), .KBD_FIFO_LOG2(KBD_FIFO_LOG2)) io (
        .clk             (clk),
        .reset_i         (reset_i),
        .bus_req_i       (io_req),
        .uart_rx_byte_i  (uart_rx_byte_i),
        .uart_rx_valid_i (uart_rx_valid_i),
        .uart_busy_i     (uart_busy_i),
        .kbd_code_i      (kbd_code_i),
        .kbd_strobe_i    (kbd_strobe_i),
        .sd_miso_i       (sd_miso_i),
        .bus_rsp_o       (io_rsp),
        .display_o       (display_o),
        .uart_tx_byte_o  (uart_tx_byte_o),
        .uart_tx_strobe_o(uart_tx_strobe_o),
        .sd_o            (sd_o)
    );

    // Unmapped addresses still get an ack, reads return zero
    always_ff @(posedge clk) begin
        if (reset_i)
            unmapped_ack <= 1'b0;
        else
            unmapped_ack <= bus_req_i.sel && !is_ram && !is_dev;
    end

    // Idle slaves drive zero, so OR is the mux
    assign bus_rsp_o.ack   = ram_rsp.ack | sys_rsp.ack | io_rsp.ack | unmapped_ack;
    assign bus_rsp_o.rdata = ram_rsp.rdata | sys_rsp.rdata | io_rsp.rdata;

endmodule

`default_nettype wire

// File: dv/soc_bus_assert.sv
//////////////////////////////////////////////////
// Bus and interrupt protocol assertions
//////////////////////////////////////////////////

`default_nettype none

module soc_bus_assert (
    input wire logic              clk,
    input wire logic              reset_i,
    input wire soc_pkg::bus_req_t req_i,
    input wire soc_pkg::bus_rsp_t rsp_i,
    input wire logic              irq_i,
    input wire logic              tx_strobe_i
);

    // Fixed one-cycle latency for every region
    ack_after_sel: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel |=> rsp_i.ack)
        else $error("bus ack missing one cycle after a request strobe");

    ack_has_strobe: assert property (@(posedge clk) disable iff (reset_i)
        rsp_i.ack |-> $past(req_i.sel))
        else $error("bus ack without a request strobe the cycle before");

    irq_low_in_reset: assert property (@(posedge clk)
        reset_i && $past(reset_i) |-> !irq_i)
        else $error("timer interrupt high during reset");

    tx_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        tx_strobe_i |=> !tx_strobe_i)
        else $error("UART transmit strobe longer than one cycle");

endmodule

`default_nettype wire

// File: dv/soc_bus_tb.sv
//////////////////////////////////////////////////
// Testbench for the SoC fabric, table-driven bus
// accesses plus a directed timer sequence
//////////////////////////////////////////////////

`default_nettype none

module soc_bus_tb;
    import soc_pkg::*;

    localparam int ACK_TIMEOUT = 10;

    // One table row, side inputs and expected read data included
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        busy;
        logic        miso;
        logic [8:0]  rx_push;
        logic [8:0]  kbd_push;
        logic        check;
        logic [31:0] exp;
    } row_t;

    logic       clk;
    logic       reset_i;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic       timer_eoi;
    logic       timer_irq;
    logic [7:0] uart_rx_byte;
    logic       uart_rx_valid;
    logic       uart_busy;
    logic [7:0] kbd_code;
    logic       kbd_strobe;
    logic       sd_miso;
    logic [7:0] display;
    logic [7:0] uart_tx_byte;
    logic       uart_tx_strobe;
    spi_pins_t  sd_pins;

    int         value_errors = 0;
    int         other_errors = 0;
    int         tx_count = 0;
    logic [7:0] tx_last = 8'd0;
    row_t       rows[$];
    string      names[$];

    soc_bus #(
        .CLK_HZ(1000), .TICK_HZ(50), .RAM_WORDS(256), .UART_FIFO_LOG2(2), .KBD_FIFO_LOG2(2)
    ) DUT (
        .clk(clk), .reset_i(reset_i), .bus_req_i(bus_req), .timer_eoi_i(timer_eoi),
        .uart_rx_byte_i(uart_rx_byte), .uart_rx_valid_i(uart_rx_valid),
        .uart_busy_i(uart_busy), .kbd_code_i(kbd_code), .kbd_strobe_i(kbd_strobe),
        .sd_miso_i(sd_miso), .bus_rsp_o(bus_rsp), .timer_irq_o(timer_irq),
        .display_o(display), .uart_tx_byte_o(uart_tx_byte),
        .uart_tx_strobe_o(uart_tx_strobe), .sd_o(sd_pins)
    );

    bind soc_bus soc_bus_assert protocol_checks (
        .clk(clk), .reset_i(reset_i), .req_i(bus_req_i), .rsp_i(bus_rsp_o),
        .irq_i(timer_irq_o), .tx_strobe_i(uart_tx_strobe_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Transmit strobes seen on the UART side
    always @(negedge clk) begin
        if (!reset_i && uart_tx_strobe) begin
            tx_count++;
            tx_last = uart_tx_byte;
        end
    end

    function automatic logic [31:0] dev_addr(input logic [3:0] page, input logic [11:0] ofs);
        return {REGION_DEV, 12'd0, page, ofs};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] mask);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++)
            if (mask[b])
                w[8*b +: 8] = new_word[8*b +: 8];
        return w;
    endfunction

    function automatic row_t make_row(input logic [31:0] addr, input logic we,
                                      input logic [31:0] wdata, input logic [31:0] exp);
        row_t r;
        r = '0;
        r.addr = addr;
        r.we = we;
        r.wdata = wdata;
        r.wmask = 4'hF;
        r.check = !we;
        r.exp = exp;
        return r;
    endfunction

    function automatic row_t with_push(input row_t r_in, input bit kbd, input logic [7:0] code);
        row_t r;
        r = r_in;
        if (kbd)
            r.kbd_push = {1'b1, code};
        else
            r.rx_push = {1'b1, code};
        return r;
    endfunction

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    // Ordering, status and overflow rows shared by both receive FIFOs
    task automatic add_fifo_rows(input string tag, input bit kbd);
        logic [31:0] stat;
        logic [31:0] code;
        logic [31:0] ne;
        stat = kbd ? dev_addr(PAGE_KBD, OFS_DATA) : dev_addr(PAGE_UART, OFS_STATUS);
        code = kbd ? dev_addr(PAGE_KBD, OFS_STATUS) : dev_addr(PAGE_UART, OFS_DATA);
        ne = kbd ? 32'd1 : 32'd2;
        for (int k = 0; k < 3; k++)
            add_row({tag, "_push"}, with_push(make_row(stat, 0, 0, ne), kbd, 8'(17 * (k + 1))));
        for (int k = 0; k < 3; k++) begin
            add_row({tag, "_dequeue"}, make_row(stat, 1, 0, 0));
            add_row({tag, "_code"}, make_row(code, 0, 0, 32'(17 * (k + 1))));
        end
        add_row({tag, "_drained"}, make_row(stat, 0, 0, 0));
        // Depth 4, so the fifth byte is dropped
        for (int k = 0; k < 5; k++)
            add_row({tag, "_fill"}, with_push(make_row(stat, 0, 0, ne), kbd, 8'(8'h41 + k)));
        for (int k = 0; k < 4; k++) begin
            add_row({tag, "_dequeue"}, make_row(stat, 1, 0, 0));
            add_row({tag, "_fill_code"}, make_row(code, 0, 0, 32'(8'h41 + k)));
        end
        add_row({tag, "_fifth_dropped"}, make_row(stat, 0, 0, 0));
        add_row({tag, "_dequeue_empty"}, make_row(stat, 1, 0, 0));
        add_row({tag, "_code_kept"}, make_row(code, 0, 0, 32'h44));
    endtask

    // Side inputs, then a one-cycle strobe, then the ack with a timeout
    task automatic apply_row(input string name, input row_t r, output logic [31:0] rdata);
        int n;
        @(posedge clk);
        uart_busy <= r.busy;
        sd_miso <= r.miso;
        uart_rx_valid <= r.rx_push[8];
        uart_rx_byte <= r.rx_push[7:0];
        kbd_strobe <= r.kbd_push[8];
        kbd_code <= r.kbd_push[7:0];
        @(posedge clk);
        uart_rx_valid <= 1'b0;
        kbd_strobe <= 1'b0;
        bus_req <= '{sel: 1'b1, addr: r.addr, we: r.we, wdata: r.wdata, wmask: r.wmask};
        @(posedge clk);
        bus_req.sel <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bus_rsp.ack && n < ACK_TIMEOUT);
        rdata = bus_rsp.rdata;
        assert (bus_rsp.ack) else begin
            $display("Timeout: no bus ack for %s", name);
            other_errors++;
        end
        if (bus_rsp.ack && r.check)
            assert (bus_rsp.rdata == r.exp) else begin
                $display("[ERROR] %s: expected %h, actual %h", name, r.exp, bus_rsp.rdata);
                value_errors++;
            end
    endtask

    task automatic wait_irq(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (timer_irq !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (timer_irq === level) else begin
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
            other_errors++;
        end
    endtask

    initial begin
        row_t        r;
        logic [31:0] full_w;
        logic [31:0] part_w;
        logic [31:0] ram_addr;
        logic [31:0] rdata;
        logic [3:0]  mask;
        spi_pins_t   exp_pins;

        reset_i = 1'b1;
        bus_req = '0;
        timer_eoi = 1'b1;
        uart_rx_byte = 8'd0;
        uart_rx_valid = 1'b0;
        uart_busy = 1'b0;
        kbd_code = 8'd0;
        kbd_strobe = 1'b0;
        sd_miso = 1'b0;
        void'($urandom(12810));
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        // RAM full writes, masked writes and merged read-back
        for (int i = 0; i < 8; i++) begin
            ram_addr = {REGION_RAM, 28'(i * 12)};
            full_w = $urandom;
            part_w = $urandom;
            mask = 4'($urandom);
            add_row($sformatf("ram_write_%0d", i), make_row(ram_addr, 1, full_w, 0));
            r = make_row(ram_addr, 1, part_w, 0);
            r.wmask = mask;
            add_row($sformatf("ram_partial_%0d", i), r);
            add_row($sformatf("ram_read_%0d", i),
                    make_row(ram_addr, 0, 0, merge_bytes(full_w, part_w, mask)));
        end

        add_row("display_write", make_row(dev_addr(PAGE_DISPLAY, OFS_DATA), 1, 32'hA5, 0));
        add_row("display_read", make_row(dev_addr(PAGE_DISPLAY, 12'h00C), 0, 0, 32'hA5));
        // mosi 1, cs 1, sclk 0
        add_row("sd_write", make_row(dev_addr(PAGE_SD, OFS_DATA), 1, 32'h3, 0));
        r = make_row(dev_addr(PAGE_SD, OFS_DATA), 0, 0, 32'd1);
        r.miso = 1'b1;
        add_row("sd_miso_read", r);
        add_row("unmapped_write", make_row(32'h7000_0010, 1, 32'hFFFF_FFFF, 0));
        add_row("unmapped_read", make_row(32'h3000_0000, 0, 0, 0));
        add_row("undefined_offset", make_row(dev_addr(PAGE_UART, 12'h008), 0, 0, 0));

        add_row("uart_tx", make_row(dev_addr(PAGE_UART, OFS_DATA), 1, 32'h5A, 0));
        r = make_row(dev_addr(PAGE_UART, OFS_STATUS), 0, 0, 32'd1);
        r.busy = 1'b1;
        add_row("uart_busy", r);
        add_fifo_rows("uart", 1'b0);
        add_fifo_rows("kbd", 1'b1);

        for (int i = 0; i < rows.size(); i++)
            apply_row(names[i], rows[i], rdata);

        exp_pins.sclk = 1'b0;
        exp_pins.csn = 1'b0;
        exp_pins.mosi = 1'b1;
        assert (display == 8'hA5) else begin
            $display("[ERROR] display_pins: expected a5, actual %h", display);
            value_errors++;
        end
        assert (sd_pins == exp_pins) else begin
            $display("[ERROR] sd_pins: expected %b, actual %b", exp_pins, sd_pins);
            value_errors++;
        end
        assert (tx_count == 1 && tx_last == 8'h5A) else begin
            $display("[ERROR] uart_tx_strobe: expected 1 x 5a, actual %0d x %h",
                     tx_count, tx_last);
            value_errors++;
        end

        // Timer ticks every 20 cycles
        apply_row("timer_enable", make_row(dev_addr(PAGE_SYS, OFS_DATA), 1, 32'd1, 0), rdata);
        apply_row("timer_enable_read", make_row(dev_addr(PAGE_SYS, OFS_DATA), 0, 0, 1), rdata);
        wait_irq(1'b1, 20, "timer interrupt");
        @(posedge clk);
        timer_eoi <= 1'b0;
        repeat (45) @(posedge clk);
        r = make_row(dev_addr(PAGE_SYS, OFS_STATUS), 0, 0, 0);
        r.check = 1'b0;
        apply_row("timer_lost_read", r, rdata);
        assert (rdata >= 2) else begin
            $display("[ERROR] timer_lost_count: expected >= 2, actual %0d", rdata);
            value_errors++;
        end
        assert (timer_irq) else begin
            $display("[ERROR] timer_irq_held: expected 1, actual %b", timer_irq);
            value_errors++;
        end
        apply_row("timer_disable", make_row(dev_addr(PAGE_SYS, OFS_DATA), 1, 32'd0, 0), rdata);
        @(posedge clk);
        timer_eoi <= 1'b1;
        wait_irq(1'b0, 5, "interrupt release after eoi");
        apply_row("timer_lost_clear", make_row(dev_addr(PAGE_SYS, OFS_STATUS), 1, 0, 0), rdata);
        apply_row("timer_lost_zero", make_row(dev_addr(PAGE_SYS, OFS_STATUS), 0, 0, 0), rdata);

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/soc_pkg.sv
verilog/byte_fifo.sv
verilog/bus_ram.sv
verilog/sys_timer.sv
verilog/io_regs.sv
verilog/soc_bus.sv
dv/soc_bus_assert.sv
dv/soc_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
